// File: design/mcu_pkg.sv
package mcu_pkg;

    // banks that one PROC pass rewrites at the same time.
    localparam int N_PROC = 2;

    // two more banks let LOAD and OUT run on blocks that PROC does not own.
    localparam int N_BANKS = N_PROC + 2;

    localparam int SUB = N_PROC / 2 + 1;  // last value of the pass counter.

    localparam int BLOCK_LEN = 8;

    typedef logic [15:0] sample_t;
    typedef logic [$clog2(BLOCK_LEN)-1:0] addr_t;
    typedef logic [$clog2(N_BANKS)-1:0] bank_idx_t;
    typedef logic [N_BANKS-1:0] bank_mask_t;
    typedef logic [$clog2(SUB + 1)-1:0] pass_t;

    // encoded as {i_eop, i_sop}.
    typedef enum logic [1:0] {
        LOAD = 2'b00,
        PROC = 2'b01,
        OUT  = 2'b10,
        IDLE = 2'b11
    } phase_e;

    // one access to a bank, from the sample writer or the prefix engine.
    typedef struct packed {
        logic    we;
        addr_t   addr;
        sample_t wdata;
    } bank_port_s;

endpackage

// File: design/mcu_ctrl.sv
module mcu_ctrl import mcu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_sop,
    input  logic       i_eop,
    input  logic       i_chblk,
    output phase_e     o_phase,
    output bank_mask_t o_we,
    output bank_idx_t  o_mem_select,
    output pass_t      o_pass
);

    phase_e     phase_in;
    phase_e     phase_q;
    phase_e     exp_phase;  // the phase whose first cycle steps a rotation.
    logic       chblk_q;
    logic       chblk_rise;
    logic       entry;
    bank_mask_t load_we;
    bank_mask_t proc_we;
    bank_idx_t  load_sel;
    bank_idx_t  out_sel;
    pass_t      pass;

    function automatic bank_idx_t next_bank(input bank_idx_t idx);
        return (idx == bank_idx_t'(N_BANKS - 1)) ? '0 : idx + 1'b1;
    endfunction

    function automatic phase_e next_phase(input phase_e ph);
        phase_e nxt;
        case (ph)
            LOAD:    nxt = PROC;
            PROC:    nxt = OUT;
            default: nxt = LOAD;
        endcase
        return nxt;
    endfunction

    assign phase_in   = phase_e'({i_eop, i_sop});
    assign chblk_rise = i_chblk && !chblk_q;
    assign entry      = (phase_in == exp_phase);

    // the rotations step on the same edge that o_phase takes the new value,
    // so the first cycle of a phase already sees the new banks.
    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q   <= IDLE;
            exp_phase <= LOAD;
            chblk_q   <= 1'b0;
            load_we   <= bank_mask_t'(1) << (N_BANKS - 1);
            proc_we   <= {{N_PROC{1'b1}}, 2'b00};
            load_sel  <= bank_idx_t'(N_BANKS - 1);
            out_sel   <= bank_idx_t'(N_BANKS - 1);
            pass      <= pass_t'(SUB);
        end else begin
            phase_q <= phase_in;
            chblk_q <= i_chblk;
            case (phase_in)
                LOAD: begin
                    if (entry || chblk_rise) begin
                        load_we  <= {load_we[N_BANKS-2:0], load_we[N_BANKS-1]};
                        load_sel <= next_bank(load_sel);
                    end
                end
                PROC: begin
                    if (entry) begin
                        proc_we <= {proc_we[1:0], proc_we[N_BANKS-1:2]};  // next pair.
                        pass    <= (pass == pass_t'(SUB)) ? '0 : pass + 1'b1;
                    end
                end
                OUT: begin
                    if (entry || chblk_rise) begin
                        out_sel <= next_bank(out_sel);
                    end
                end
                default: begin
                end
            endcase
            if (entry) begin
                exp_phase <= next_phase(exp_phase);
            end
        end
    end

    always_comb begin
        o_we         = '0;
        o_mem_select = '0;
        case (phase_q)
            LOAD: begin
                o_we         = load_we;
                o_mem_select = load_sel;
            end
            PROC: begin
                o_we = proc_we;
            end
            OUT: begin
                o_mem_select = out_sel;  // banks are only read here.
            end
            default: begin
            end
        endcase
    end

    assign o_phase = phase_q;
    assign o_pass  = pass;

endmodule

// File: design/bank_slot.sv
module bank_slot import mcu_pkg::*; (
    input  logic       clk,
    input  phase_e     i_phase,
    input  logic       i_we,
    input  bank_port_s i_load_port,
    input  bank_port_s i_proc_port,
    input  addr_t      i_read_addr,
    output sample_t    o_rdata
);

    sample_t mem [BLOCK_LEN];
    logic    wr;
    addr_t   waddr;
    addr_t   raddr;
    sample_t wdata;

    always_comb begin
        wr    = 1'b0;
        waddr = i_load_port.addr;
        wdata = i_load_port.wdata;
        raddr = i_read_addr;
        case (i_phase)
            LOAD: begin
                wr = i_we && i_load_port.we;
            end
            PROC: begin
                wr    = i_we && i_proc_port.we;
                waddr = i_proc_port.addr;
                wdata = i_proc_port.wdata;
                // the engine names the word it writes, and reads one word ahead.
                raddr = i_proc_port.addr + addr_t'(1);
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[waddr] <= wdata;
        end
        o_rdata <= mem[raddr];
    end

endmodule

// File: design/sample_writer.sv
module sample_writer import mcu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  phase_e     i_phase,
    input  logic       i_chblk,
    input  sample_t    i_data,
    output bank_port_s o_port
);

    addr_t addr;
    logic  chblk_q;
    logic  restart;

    // a new block starts at word 0, both on entry to LOAD and after i_chblk rises.
    assign restart = (i_phase != LOAD) || (i_chblk && !chblk_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            addr    <= '0;
            chblk_q <= 1'b0;
        end else begin
            chblk_q <= i_chblk;
            if (restart) begin
                addr <= '0;
            end else begin
                addr <= addr + 1'b1;
            end
        end
    end

    // every LOAD cycle stores one sample.
    // the controller's one-hot enable picks the bank.
    always_comb begin
        o_port.we    = (i_phase == LOAD);
        o_port.addr  = addr;
        o_port.wdata = i_data;
    end

endmodule

// File: design/prefix_engine.sv
module prefix_engine import mcu_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  phase_e                      i_phase,
    input  sample_t    [N_BANKS-1:0]    i_rdata,
    output bank_port_s [N_BANKS-1:0]    o_port,
    output logic                        o_proc_done
);

    logic [$clog2(BLOCK_LEN + 1)-1:0] step;
    sample_t [N_BANKS-1:0]            acc;
    sample_t [N_BANKS-1:0]            sum;
    logic                             wr;
    addr_t                            waddr;

    // step 0 only reads word 0. Step k writes word k-1 and reads word k.
    assign wr    = (i_phase == PROC) && (step != '0) && !o_proc_done;
    assign waddr = addr_t'(step - 1'b1);

    always_ff @(posedge clk) begin
        if (rst || (i_phase != PROC)) begin
            step        <= '0;
            o_proc_done <= 1'b0;
        end else begin
            if (step != BLOCK_LEN) begin
                step <= step + 1'b1;
            end
            o_proc_done <= o_proc_done || (step == BLOCK_LEN);  // held to the end of PROC.
        end
    end

    // every bank keeps its own running sum.
    // the controller's mask decides which of them are written back.
    always_ff @(posedge clk) begin
        for (int b = 0; b < N_BANKS; b++) begin
            if (i_phase != PROC) begin
                acc[b] <= '0;
            end else if (wr) begin
                acc[b] <= sum[b];
            end
        end
    end

    always_comb begin
        for (int b = 0; b < N_BANKS; b++) begin
            sum[b]          = acc[b] + i_rdata[b];  // wraps on overflow.
            o_port[b].we    = wr;
            o_port[b].addr  = waddr;
            o_port[b].wdata = sum[b];
        end
    end

endmodule

// File: design/block_reader.sv
module block_reader import mcu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  phase_e                i_phase,
    input  logic                  i_chblk,
    input  bank_idx_t             i_mem_select,
    input  sample_t [N_BANKS-1:0] i_rdata,
    output addr_t                 o_read_addr,
    output sample_t               o_data,
    output logic                  o_valid
);

    addr_t     addr;
    logic      active;   // high while the block still has words to issue.
    logic      chblk_q;
    logic      chblk_rise;
    bank_idx_t sel_q;

    assign chblk_rise = i_chblk && !chblk_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            addr    <= '0;
            active  <= 1'b1;
            chblk_q <= 1'b0;
            o_valid <= 1'b0;
        end else begin
            chblk_q <= i_chblk;
            o_valid <= (i_phase == OUT) && active;
            if ((i_phase != OUT) || chblk_rise) begin
                addr   <= '0;
                active <= 1'b1;
            end else if (active) begin
                addr <= addr + 1'b1;
                if (addr == addr_t'(BLOCK_LEN - 1)) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // the bank answers one cycle later, so the select is delayed to match.
    always_ff @(posedge clk) begin
        sel_q <= i_mem_select;
    end

    assign o_read_addr = addr;
    assign o_data      = i_rdata[sel_q];

endmodule

// File: design/block_buffer_top.sv
module block_buffer_top import mcu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    i_sop,
    input  logic    i_eop,
    input  logic    i_chblk,
    input  sample_t i_data,
    output sample_t o_data,
    output logic    o_valid,
    output logic    o_proc_done,
    output pass_t   o_pass
);

    phase_e                      phase;
    bank_mask_t                  we_mask;
    bank_idx_t                   mem_select;
    bank_port_s                  load_port;
    bank_port_s [N_BANKS-1:0]    proc_port;
    addr_t                       read_addr;
    sample_t    [N_BANKS-1:0]    rdata;

    mcu_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .i_sop        (i_sop),
        .i_eop        (i_eop),
        .i_chblk      (i_chblk),
        .o_phase      (phase),
        .o_we         (we_mask),
        .o_mem_select (mem_select),
        .o_pass       (o_pass)
    );

    sample_writer u_writer (
        .clk     (clk),
        .rst     (rst),
        .i_phase (phase),
        .i_chblk (i_chblk),
        .i_data  (i_data),
        .o_port  (load_port)
    );

    prefix_engine u_engine (
        .clk         (clk),
        .rst         (rst),
        .i_phase     (phase),
        .i_rdata     (rdata),
        .o_port      (proc_port),
        .o_proc_done (o_proc_done)
    );

    block_reader u_reader (
        .clk          (clk),
        .rst          (rst),
        .i_phase      (phase),
        .i_chblk      (i_chblk),
        .i_mem_select (mem_select),
        .i_rdata      (rdata),
        .o_read_addr  (read_addr),
        .o_data       (o_data),
        .o_valid      (o_valid)
    );

    // each bank writes only while its bit of the controller's mask is set.
    for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
        bank_slot u_slot (
            .clk         (clk),
            .i_phase     (phase),
            .i_we        (we_mask[b]),
            .i_load_port (load_port),
            .i_proc_port (proc_port[b]),
            .i_read_addr (read_addr),
            .o_rdata     (rdata[b])
        );
    end

endmodule

// File: testbench/tb_block_buffer.sv
module tb_block_buffer import mcu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // what the DUT should show in the coming cycle.
    typedef struct packed {
        logic    valid;
        sample_t data;
        logic    done;
        pass_t   pass;
    } expect_s;

    logic    clk;
    logic    rst;
    logic    i_sop;
    logic    i_eop;
    logic    i_chblk;
    sample_t i_data;
    sample_t o_data;
    logic    o_valid;
    logic    o_proc_done;
    pass_t   o_pass;

    int seed = 32'h106f;
    int cycle_count = 0;
    int words_seen = 0;
    int words_expected = 0;

    phase_e    ph_in;
    phase_e    m_phase;      // the phase as the DUT sees it, one cycle late.
    logic      m_chblk_q;
    bank_idx_t load_bank;
    bank_idx_t proc_base;    // lowest bank of the pair that PROC owns.
    bank_idx_t out_bank;
    addr_t     load_addr;
    addr_t     rd_addr;
    int        rd_left;
    int        proc_cycles;
    int        proc_entries; // PROC phases entered so far.
    sample_t   model_mem [N_BANKS][BLOCK_LEN];
    expect_s   model_out;

    block_buffer_top u_block_buffer_top (
        .clk         (clk),
        .rst         (rst),
        .i_sop       (i_sop),
        .i_eop       (i_eop),
        .i_chblk     (i_chblk),
        .i_data      (i_data),
        .o_data      (o_data),
        .o_valid     (o_valid),
        .o_proc_done (o_proc_done),
        .o_pass      (o_pass)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    assign ph_in = phase_e'({i_eop, i_sop});

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Fail at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
        abort_run();
    endtask

    task automatic set_phase(input phase_e ph);
        {i_eop, i_sop} = ph;
    endtask

    // the last word of every block but the final one carries the i_chblk rise.
    task automatic load_blocks(input int n_blocks);
        int b;
        int a;
        set_phase(LOAD);
        for (b = 0; b < n_blocks; b++) begin
            for (a = 0; a < BLOCK_LEN; a++) begin
                @(negedge clk);
                i_data  = sample_t'($random(seed));
                i_chblk = (a == BLOCK_LEN - 1) && (b != n_blocks - 1);
                if ((a == BLOCK_LEN - 1) && (b == n_blocks - 1)) begin
                    set_phase(PROC);  // the DUT still stores this word.
                end
            end
        end
    endtask

    task automatic wait_proc_done();
        do begin
            @(negedge clk);
        end while (!o_proc_done);
    endtask

    task automatic read_blocks(input int n_blocks);
        int b;
        set_phase(OUT);
        for (b = 0; b < n_blocks; b++) begin
            if (b != 0) begin
                i_chblk = 1'b1;
                @(negedge clk);
                i_chblk = 1'b0;
            end
            do begin
                @(negedge clk);
            end while (!o_valid);
            while (o_valid) begin
                @(negedge clk);
            end
        end
        words_expected += n_blocks * BLOCK_LEN;
    endtask

    task automatic run_round(input int n_load, input int n_out);
        load_blocks(n_load);
        wait_proc_done();
        read_blocks(n_out);
        set_phase(IDLE);
        repeat (2) @(negedge clk);
    endtask

    // reference model of the bank rotations and bank contents.
    always @(posedge clk) begin
        logic      entering;
        logic      chblk_edge;
        bank_idx_t pb;
        sample_t   acc;
        int        i;
        int        a;
        if (rst) begin
            m_phase      <= IDLE;
            m_chblk_q    <= 1'b0;
            load_bank    <= bank_idx_t'(N_BANKS - 1);  // first LOAD lands on bank 0.
            proc_base    <= bank_idx_t'(N_PROC);
            out_bank     <= bank_idx_t'(N_BANKS - 1);
            load_addr    <= '0;
            rd_addr      <= '0;
            rd_left      <= 0;
            proc_cycles  <= 0;
            proc_entries <= 0;
            model_out      <= '0;
            model_out.pass <= pass_t'(SUB);  // no pass has run yet.
        end else begin
            entering   = (ph_in != m_phase);
            chblk_edge = i_chblk && !m_chblk_q;
            m_phase   <= ph_in;
            m_chblk_q <= i_chblk;

            if (m_phase == LOAD) begin
                model_mem[load_bank][load_addr] <= i_data;
                load_addr <= load_addr + 1'b1;
            end else begin
                load_addr <= '0;
            end
            if ((ph_in == LOAD) && (entering || chblk_edge)) begin
                load_bank <= load_bank + 1'b1;
                load_addr <= '0;
            end

            if ((ph_in == PROC) && entering) begin
                proc_base      <= proc_base + bank_idx_t'(N_PROC);
                proc_entries   <= proc_entries + 1;
                // passes are numbered 0 to SUB in turn.
                model_out.pass <= pass_t'(proc_entries % (SUB + 1));
            end
            if (m_phase != PROC) begin
                proc_cycles    <= 0;
                model_out.done <= 1'b0;
            end else if (!model_out.done) begin
                if (proc_cycles == BLOCK_LEN) begin
                    model_out.done <= 1'b1;
                    for (i = 0; i < N_PROC; i++) begin
                        pb  = bank_idx_t'(proc_base + i);
                        acc = '0;
                        for (a = 0; a < BLOCK_LEN; a++) begin
                            acc = acc + model_mem[pb][a];
                            model_mem[pb][a] <= acc;
                        end
                    end
                end else begin
                    proc_cycles <= proc_cycles + 1;
                end
            end

            if ((m_phase == OUT) && (rd_left != 0)) begin
                model_out.valid <= 1'b1;
                model_out.data  <= model_mem[out_bank][rd_addr];
                rd_addr <= rd_addr + 1'b1;
                rd_left <= rd_left - 1;
            end else begin
                model_out.valid <= 1'b0;
            end
            if ((m_phase != OUT) || chblk_edge) begin
                rd_addr <= '0;
                rd_left <= BLOCK_LEN;
            end
            if ((ph_in == OUT) && (entering || chblk_edge)) begin
                out_bank <= out_bank + 1'b1;
            end
        end
    end

    valid_check: assert property (@(posedge clk) disable iff (rst)
        o_valid == model_out.valid)
        else report_mismatch("o_valid", 32'($sampled(model_out.valid)), 32'($sampled(o_valid)));

    data_check: assert property (@(posedge clk) disable iff (rst)
        o_valid |-> (o_data == model_out.data))
        else report_mismatch("o_data", 32'($sampled(model_out.data)), 32'($sampled(o_data)));

    done_check: assert property (@(posedge clk) disable iff (rst)
        o_proc_done == model_out.done)
        else report_mismatch("o_proc_done", 32'($sampled(model_out.done)),
                             32'($sampled(o_proc_done)));

    pass_check: assert property (@(posedge clk) disable iff (rst)
        o_pass == model_out.pass)
        else report_mismatch("o_pass", 32'($sampled(model_out.pass)), 32'($sampled(o_pass)));

    // the whole run takes well under 40 blocks of a few cycles each.
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == 40 * (BLOCK_LEN + 2)) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_count);
            abort_run();
        end
    end

    always @(negedge clk) begin
        if (o_valid) begin
            words_seen <= words_seen + 1;
        end
    end

    initial begin
        rst     = 1'b1;
        i_sop   = 1'b1;
        i_eop   = 1'b1;
        i_chblk = 1'b0;
        i_data  = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);  // idle, nothing may come out.

        run_round(2, 2);  // banks 0 and 1 summed and read.
        run_round(3, 4);  // bank 0 is read back unprocessed.
        run_round(1, 2);
        run_round(2, 2);  // fourth pass wraps the pass counter.

        if (words_seen == words_expected) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("wrong number of output samples: %0d seen, %0d expected",
                     words_seen, words_expected);
            abort_run();
        end
    end

endmodule

// File: list.f
design/mcu_pkg.sv
design/mcu_ctrl.sv
design/bank_slot.sv
design/sample_writer.sv
design/prefix_engine.sv
design/block_reader.sv
design/block_buffer_top.sv
testbench/tb_block_buffer.sv

// File: Makefile
# Verilator build and run of the block buffer testbench.

VERILATOR  ?= verilator
TOP        ?= tb_block_buffer
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/1ps
VFLAGS     ?= --binary --assert --timing -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_TEXT)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
